// File: design/uartPkg.sv
package uartPkg;

	// ################################################
	// word widths
	// ################################################

	// processor bus data word
	parameter int WORD_WIDTH = 16;
	// one serial character, 8N1 framing
	parameter int BYTE_WIDTH = 8;

	// ################################################
	// register map
	// ################################################

	// status flags, write any value to clear tx irq
	parameter logic [1:0] ADDR_STATUS = 2'd0;
	// rx byte on read, tx byte on write
	parameter logic [1:0] ADDR_DATA = 2'd1;
	// clocks per bit, receive side
	parameter logic [1:0] ADDR_RX_DIV = 2'd2;
	// clocks per bit, transmit side
	parameter logic [1:0] ADDR_TX_DIV = 2'd3;

	// ################################################
	// status word bit positions
	// ################################################

	// bits 5 and up read zero
	parameter int STATUS_RX_AVAIL = 0;
	parameter int STATUS_TX_ACTIVE = 1;
	parameter int STATUS_TX_DONE = 2;
	parameter int STATUS_TX_IRQ = 3;
	parameter int STATUS_RX_IRQ = 4;

endpackage

// File: design/uartTxIf.sv
`timescale 1ns/1ps

interface uartTxIf
	import uartPkg::*;
();

	// request from the register block
	logic startTx;
	logic [BYTE_WIDTH-1:0] txByte;
	logic [WORD_WIDTH-1:0] txClkDiv;

	// state reported back by the transmitter
	logic txActive;
	// one cycle, last cycle of the stop bit
	logic txDone;

	// register side
	modport ctrl (
		output startTx, txByte, txClkDiv,
		input txActive, txDone
	);

	// serial line side
	modport line (
		input startTx, txByte, txClkDiv,
		output txActive, txDone
	);

endinterface

// File: design/uartReceiver.sv
`timescale 1ns/1ps

module uartReceiver import uartPkg::*; (
	input  logic CLK,
	input  logic RESET,
	input  logic i_rxd,
	input  logic [WORD_WIDTH-1:0] i_clkDiv,
	output logic o_valid,
	output logic [BYTE_WIDTH-1:0] o_byte
);

	// frame states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_START = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_STOP = 2'd3;

	logic [1:0] state;
	logic rxMeta;
	logic rxSync;
	logic rxLast;
	logic [WORD_WIDTH-1:0] bitCnt;
	logic [WORD_WIDTH-1:0] bitEnd;
	logic [WORD_WIDTH-1:0] halfEnd;
	logic [2:0] bitIdx;
	logic [BYTE_WIDTH-1:0] shiftReg;
	logic bitDone;

	// last count of a full bit and of half a bit
	assign bitEnd = (i_clkDiv != '0) ? i_clkDiv - 1'b1 : '0;
	assign halfEnd = (i_clkDiv > 16'd1) ? (i_clkDiv >> 1) - 1'b1 : '0;
	assign bitDone = (bitCnt >= bitEnd);

	// ################################################
	// frame FSM
	// ################################################

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxLast <= 1'b1;
			state <= ST_IDLE;
			bitCnt <= '0;
			bitIdx <= '0;
			o_valid <= 1'b0;
			o_byte <= '0;
		end else begin
			// two flop synchronizer, then edge history
			rxMeta <= i_rxd;
			rxSync <= rxMeta;
			rxLast <= rxSync;
			o_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					// falling edge marks a possible start bit
					if (rxLast && !rxSync) begin
						state <= ST_START;
						bitCnt <= '0;
					end
				end
				ST_START: begin
					if (bitCnt >= halfEnd) begin
						bitCnt <= '0;
						bitIdx <= '0;
						// still low at mid start bit, else treat as a glitch
						state <= rxSync ? ST_IDLE : ST_DATA;
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				ST_DATA: begin
					if (bitDone) begin
						bitCnt <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7) begin
							state <= ST_STOP;
						end
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				default: begin
					// middle of stop bit, hand the byte over
					if (bitDone) begin
						o_valid <= 1'b1;
						o_byte <= shiftReg;
						bitCnt <= '0;
						state <= ST_IDLE;
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge CLK) begin
		if (state == ST_DATA && bitDone) begin
			shiftReg <= {rxSync, shiftReg[BYTE_WIDTH-1:1]};
		end
	end

endmodule

// File: design/uartTransmitter.sv
`timescale 1ns/1ps

module uartTransmitter import uartPkg::*; (
	input  logic CLK,
	input  logic RESET,
	output logic o_txd,
	uartTxIf.line tx
);

	// frame states
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_START = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_STOP = 2'd3;

	logic [1:0] state;
	logic [WORD_WIDTH-1:0] bitCnt;
	logic [WORD_WIDTH-1:0] bitEnd;
	logic [2:0] bitIdx;
	logic [BYTE_WIDTH-1:0] shiftReg;
	logic bitDone;

	// each bit lasts txClkDiv cycles
	assign bitEnd = (tx.txClkDiv != '0) ? tx.txClkDiv - 1'b1 : '0;
	assign bitDone = (bitCnt >= bitEnd);

	// busy from start bit through stop bit
	assign tx.txActive = (state != ST_IDLE);
	// high in the last cycle of the stop bit only
	assign tx.txDone = (state == ST_STOP) && bitDone;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state <= ST_IDLE;
			bitCnt <= '0;
			bitIdx <= '0;
			o_txd <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					// requests while busy never reach here
					if (tx.startTx) begin
						state <= ST_START;
						bitCnt <= '0;
						o_txd <= 1'b0;
					end
				end
				ST_START: begin
					if (bitDone) begin
						state <= ST_DATA;
						bitCnt <= '0;
						bitIdx <= '0;
						o_txd <= shiftReg[0];
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				ST_DATA: begin
					if (bitDone) begin
						bitCnt <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7) begin
							state <= ST_STOP;
							o_txd <= 1'b1;
						end else begin
							o_txd <= shiftReg[0];
						end
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				default: begin
					// line already high, just wait out the stop bit
					if (bitDone) begin
						state <= ST_IDLE;
						bitCnt <= '0;
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
			endcase
		end
	end

	// load at start, next bit lands in position 0 at every boundary
	always_ff @(posedge CLK) begin
		if (state == ST_IDLE && tx.startTx) begin
			shiftReg <= tx.txByte;
		end else if (bitDone && (state == ST_START || state == ST_DATA)) begin
			shiftReg <= shiftReg >> 1;
		end
	end

endmodule

// File: design/uartRegisters.sv
`timescale 1ns/1ps

module uartRegisters import uartPkg::*; #(
	parameter int unsigned DEFAULT_CLK_DIV = 104
) (
	input  logic CLK,
	input  logic RESET,
	input  logic i_rd,
	input  logic i_wr,
	input  logic [1:0] i_addr,
	input  logic [WORD_WIDTH-1:0] i_din,
	output logic [WORD_WIDTH-1:0] o_dout,
	output logic o_irq,
	input  logic i_rxValid,
	input  logic [BYTE_WIDTH-1:0] i_rxByte,
	output logic [WORD_WIDTH-1:0] o_rxClkDiv,
	uartTxIf.ctrl tx
);

	// latched status flags
	logic rxAvail;
	logic txDoneFlag;
	logic txIrq;
	logic rxIrq;

	logic startTx;
	logic [BYTE_WIDTH-1:0] txByte;
	logic [WORD_WIDTH-1:0] rxClkDiv;
	logic [WORD_WIDTH-1:0] txClkDiv;
	logic [WORD_WIDTH-1:0] status;
	logic [WORD_WIDTH-1:0] rdData;

	// ################################################
	// status word and outputs
	// ################################################

	always_comb begin
		status = '0;
		status[STATUS_RX_AVAIL] = rxAvail;
		// live copy of the transmitter state
		status[STATUS_TX_ACTIVE] = tx.txActive;
		status[STATUS_TX_DONE] = txDoneFlag;
		status[STATUS_TX_IRQ] = txIrq;
		status[STATUS_RX_IRQ] = rxIrq;
	end

	// single interrupt line for both directions
	assign o_irq = status[STATUS_TX_IRQ] | status[STATUS_RX_IRQ];

	assign tx.startTx = startTx;
	assign tx.txByte = txByte;
	assign tx.txClkDiv = txClkDiv;
	assign o_rxClkDiv = rxClkDiv;

	// read mux ahead of the output register
	always_comb begin
		case (i_addr)
			ADDR_STATUS: rdData = status;
			ADDR_DATA: rdData = {{(WORD_WIDTH - BYTE_WIDTH){1'b0}}, i_rxByte};
			ADDR_RX_DIV: rdData = rxClkDiv;
			ADDR_TX_DIV: rdData = txClkDiv;
			default: rdData = '0;
		endcase
	end

	// ################################################
	// register and flag updates
	// ################################################

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			o_dout <= '0;
			startTx <= 1'b0;
			rxAvail <= 1'b0;
			txDoneFlag <= 1'b1;
			txIrq <= 1'b0;
			rxIrq <= 1'b0;
			rxClkDiv <= WORD_WIDTH'(DEFAULT_CLK_DIV);
			txClkDiv <= WORD_WIDTH'(DEFAULT_CLK_DIV);
		end else begin
			// read data valid for one cycle, zero otherwise
			o_dout <= i_rd ? rdData : '0;

			// request held until the transmitter goes busy
			if (tx.txActive) begin
				startTx <= 1'b0;
			end

			// data read acknowledges the received byte
			if (i_rd && i_addr == ADDR_DATA) begin
				rxAvail <= 1'b0;
				rxIrq <= 1'b0;
			end

			if (i_wr) begin
				case (i_addr)
					ADDR_STATUS: begin
						txIrq <= 1'b0;
					end
					ADDR_DATA: begin
						startTx <= 1'b1;
						txDoneFlag <= 1'b0;
						txIrq <= 1'b0;
					end
					ADDR_RX_DIV: begin
						rxClkDiv <= i_din;
					end
					ADDR_TX_DIV: begin
						txClkDiv <= i_din;
					end
				endcase
			end

			// completion events override a same-cycle clear
			if (i_rxValid) begin
				rxAvail <= 1'b1;
				rxIrq <= 1'b1;
			end
			if (tx.txDone) begin
				txDoneFlag <= 1'b1;
				txIrq <= 1'b1;
			end
		end
	end

	// outgoing byte taken at the data write
	always_ff @(posedge CLK) begin
		if (i_wr && i_addr == ADDR_DATA) begin
			txByte <= i_din[BYTE_WIDTH-1:0];
		end
	end

endmodule

// File: design/uartTop.sv
`timescale 1ns/1ps

module uartTop import uartPkg::*; #(
	// 12 MHz clock at 115200 baud
	parameter int unsigned DEFAULT_CLK_DIV = 104
) (
	input  logic CLK,
	input  logic RESET,
	input  logic i_rd,
	input  logic i_wr,
	input  logic [1:0] i_addr,
	input  logic [WORD_WIDTH-1:0] i_din,
	output logic [WORD_WIDTH-1:0] o_dout,
	output logic o_irq,
	input  logic i_rxd,
	output logic o_txd
);

	// receive path
	logic rxValid;
	logic [BYTE_WIDTH-1:0] rxByte;
	logic [WORD_WIDTH-1:0] rxClkDiv;

	// transmit request and status
	uartTxIf txBus ();

	uartRegisters #(
		.DEFAULT_CLK_DIV(DEFAULT_CLK_DIV)
	) regsInst (
		.CLK(CLK),
		.RESET(RESET),
		.i_rd(i_rd),
		.i_wr(i_wr),
		.i_addr(i_addr),
		.i_din(i_din),
		.o_dout(o_dout),
		.o_irq(o_irq),
		.i_rxValid(rxValid),
		.i_rxByte(rxByte),
		.o_rxClkDiv(rxClkDiv),
		.tx(txBus.ctrl)
	);

	uartTransmitter txInst (
		.CLK(CLK),
		.RESET(RESET),
		.o_txd(o_txd),
		.tx(txBus.line)
	);

	uartReceiver rxInst (
		.CLK(CLK),
		.RESET(RESET),
		.i_rxd(i_rxd),
		.i_clkDiv(rxClkDiv),
		.o_valid(rxValid),
		.o_byte(rxByte)
	);

endmodule

// File: tests/uartTop_checker.sv
`timescale 1ns/1ps

module uartTop_checker import uartPkg::*; (
	input logic CLK,
	input logic RESET,
	input logic i_rd,
	input logic i_wr,
	input logic i_txLine,
	input logic i_irq,
	input logic i_txActive,
	input logic [WORD_WIDTH-1:0] i_status
);

	// ################################################
	// bus protocol
	// ################################################

	// one strobe per cycle from the processor
	rdWrExclusive: assert property (@(posedge CLK) disable iff (RESET) !(i_rd && i_wr))
		else $error("i_rd and i_wr high in the same cycle");

	// ################################################
	// serial line and interrupt
	// ################################################

	// line idles high outside a frame
	txIdleHigh: assert property (@(posedge CLK) disable iff (RESET) !i_txActive |-> i_txLine)
		else $error("o_txd low while the transmitter is inactive");

	// irq only drops after a bus access clears a flag
	irqClearedByAccess: assert property (@(posedge CLK) disable iff (RESET)
		$fell(i_irq) |-> $past(i_rd || i_wr))
		else $error("o_irq dropped without a bus access");

	// rx irq only drops after a read
	rxIrqClearedByRead: assert property (@(posedge CLK) disable iff (RESET)
		$fell(i_status[STATUS_RX_IRQ]) |-> $past(i_rd))
		else $error("receive interrupt flag cleared without a read");

endmodule

bind uartTop uartTop_checker checkInst (
	.CLK(CLK),
	.RESET(RESET),
	.i_rd(i_rd),
	.i_wr(i_wr),
	.i_txLine(o_txd),
	.i_irq(o_irq),
	.i_txActive(txBus.txActive),
	.i_status(regsInst.status)
);

// File: tests/uartTb.sv
`timescale 1ns/1ps

module uartTb import uartPkg::*; ();

	localparam int MAX_RECORDS = 64;
	// test, op, addr, data, expected
	localparam int FIELDS = 5;
	// both dividers come out of reset at this value
	localparam int RESET_DIV = 104;

	// record operations
	localparam logic [15:0] OP_READ = 16'd0;
	localparam logic [15:0] OP_WRITE = 16'd1;
	localparam logic [15:0] OP_SEND = 16'd2;
	localparam logic [15:0] OP_EXPECT = 16'd3;
	localparam logic [15:0] OP_POLL = 16'd4;
	localparam logic [15:0] OP_IRQ = 16'd5;
	localparam logic [15:0] OP_IDLE = 16'd6;
	localparam logic [15:0] OP_LOOP = 16'd7;

	logic CLK;
	logic RESET;
	logic i_rd;
	logic i_wr;
	logic [1:0] i_addr;
	logic [WORD_WIDTH-1:0] i_din;
	logic [WORD_WIDTH-1:0] o_dout;
	logic o_irq;
	wire i_rxd;
	logic o_txd;

	// serial input source, driven or looped back
	logic rxLine;
	logic loopBack;
	logic [15:0] stim [0:MAX_RECORDS*FIELDS-1];
	int recordCount;
	int rxDiv;
	int txDiv;
	int maxDiv;
	int pollLimit;
	int cycleCount;
	int cycleLimit;
	int errorCount;
	int checkCount;

	assign i_rxd = loopBack ? o_txd : rxLine;

	uartTop #(
		.DEFAULT_CLK_DIV(RESET_DIV)
	) dut (
		.CLK(CLK),
		.RESET(RESET),
		.i_rd(i_rd),
		.i_wr(i_wr),
		.i_addr(i_addr),
		.i_din(i_din),
		.o_dout(o_dout),
		.o_irq(o_irq),
		.i_rxd(i_rxd),
		.o_txd(o_txd)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// watchdog, limit set once the records are loaded
	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("timeout after %0d cycles, the DUT never completed the test", cycleCount);
			$display("Finished with errors");
			$finish;
		end
	end

	// ################################################
	// helpers
	// ################################################

	function automatic string testName(input int id);
		case (id)
			1: return "reset state";
			2: return "divider access";
			3: return "transmit";
			4: return "receive";
			5: return "overwrite";
			6: return "loopback";
			default: return "unknown test";
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
		end
	endtask

	// bus tasks start and end on a falling edge
	task automatic busWrite(input logic [1:0] addr, input logic [15:0] data);
		i_wr = 1'b1;
		i_addr = addr;
		i_din = data;
		@(negedge CLK);
		i_wr = 1'b0;
	endtask

	task automatic busRead(input logic [1:0] addr, output logic [15:0] data);
		i_rd = 1'b1;
		i_addr = addr;
		@(negedge CLK);
		i_rd = 1'b0;
		// registered read data, valid since the last rising edge
		data = o_dout;
	endtask

	// 8N1 frame onto i_rxd, lsb first
	task automatic sendSerial(input logic [7:0] value, input int div);
		rxLine = 1'b0;
		repeat (div) @(negedge CLK);
		for (int i = 0; i < 8; i++) begin
			rxLine = value[i];
			repeat (div) @(negedge CLK);
		end
		rxLine = 1'b1;
		repeat (div) @(negedge CLK);
	endtask

	// returns at mid stop bit
	task automatic receiveSerial(input string name, input int div, output logic [7:0] value);
		value = '0;
		while (o_txd !== 1'b0) begin
			@(negedge CLK);
		end
		repeat (div / 2) @(negedge CLK);
		if (o_txd !== 1'b0) begin
			errorCount++;
			$display("%s: start bit on o_txd did not last to mid-bit", name);
		end
		for (int i = 0; i < 8; i++) begin
			repeat (div) @(negedge CLK);
			value[i] = o_txd;
		end
		repeat (div) @(negedge CLK);
		if (o_txd !== 1'b1) begin
			errorCount++;
			$display("%s: stop bit missing on o_txd", name);
		end
	endtask

	task automatic pollReg(input string name, input logic [1:0] addr, input logic [15:0] mask,
			input logic [15:0] expected);
		logic [15:0] value;
		int tries;
		tries = 1;
		busRead(addr, value);
		while (((value & mask) !== expected) && tries < pollLimit) begin
			busRead(addr, value);
			tries++;
		end
		checkCount++;
		if ((value & mask) !== expected) begin
			errorCount++;
			$display("%s: register %0d never reached 0x%h under mask 0x%h", name, addr,
				expected, mask);
		end
	endtask

	// ################################################
	// record player
	// ################################################

	initial begin
		logic [15:0] op;
		logic [1:0] addr;
		logic [15:0] data;
		logic [15:0] expected;
		logic [15:0] value;
		logic [7:0] rxValue;
		string name;
		RESET = 1'b1;
		i_rd = 1'b0;
		i_wr = 1'b0;
		i_addr = '0;
		i_din = '0;
		rxLine = 1'b1;
		loopBack = 1'b0;
		errorCount = 0;
		checkCount = 0;
		cycleCount = 0;
		rxDiv = RESET_DIV;
		txDiv = RESET_DIV;
		$readmemh("tests/uartStimulus.txt", stim);
		recordCount = 0;
		while (recordCount < MAX_RECORDS && !$isunknown(stim[recordCount*FIELDS])) begin
			recordCount++;
		end
		// slowest divider any record sets
		maxDiv = RESET_DIV;
		for (int n = 0; n < recordCount; n++) begin
			if (stim[n*FIELDS+1] == OP_WRITE && stim[n*FIELDS+2] >= 16'(ADDR_RX_DIV)
					&& stim[n*FIELDS+3] > maxDiv) begin
				maxDiv = stim[n*FIELDS+3];
			end
		end
		cycleLimit = recordCount * 20 * maxDiv + 200;
		pollLimit = 20 * maxDiv;

		repeat (8) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b0;
		@(negedge CLK);

		for (int n = 0; n < recordCount; n++) begin
			op = stim[n*FIELDS+1];
			addr = stim[n*FIELDS+2][1:0];
			data = stim[n*FIELDS+3];
			expected = stim[n*FIELDS+4];
			name = $sformatf("%s, record %0d", testName(stim[n*FIELDS]), n);
			case (op)
				OP_READ: begin
					// data field masks bits that may move
					busRead(addr, value);
					checkValue(name, expected, value & data);
				end
				OP_WRITE: begin
					busWrite(addr, data);
					if (addr == ADDR_RX_DIV) begin
						rxDiv = data;
					end
					if (addr == ADDR_TX_DIV) begin
						txDiv = data;
					end
				end
				OP_SEND: begin
					sendSerial(data[7:0], rxDiv);
				end
				OP_EXPECT: begin
					receiveSerial(name, txDiv, rxValue);
					checkValue(name, expected, {8'h00, rxValue});
				end
				OP_POLL: begin
					pollReg(name, addr, data, expected);
				end
				OP_IRQ: begin
					checkValue(name, expected, {15'b0, o_irq});
				end
				OP_IDLE: begin
					// a cycle with no read leaves o_dout at zero
					@(negedge CLK);
					checkValue(name, expected, o_dout);
				end
				OP_LOOP: begin
					loopBack = data[0];
				end
				default: begin
					errorCount++;
					$display("unknown operation %0h in record %0d", op, n);
				end
			endcase
		end

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: tests/uartStimulus.txt
// test op addr data expected, all hex
// op 0 read (data masks), 1 write, 2 send rxd, 3 expect txd, 4 poll, 5 irq, 6 idle, 7 loop
1 0 0 ffff 0004
1 0 2 ffff 0068
1 0 3 ffff 0068
1 5 0 0000 0000
1 6 0 0000 0000
2 1 2 0008 0000
2 1 3 0008 0000
2 0 2 ffff 0008
2 0 3 ffff 0008
2 0 0 ffff 0004
3 1 1 12c3 0000
3 3 0 0000 00c3
3 0 0 0002 0002
3 4 0 001c 000c
3 5 0 0000 0001
3 1 0 0000 0000
3 0 0 001f 0004
3 5 0 0000 0000
4 2 0 005a 0000
4 4 0 0011 0011
4 5 0 0000 0001
4 0 1 00ff 005a
4 0 0 0011 0000
4 5 0 0000 0000
5 2 0 0033 0000
5 2 0 00cc 0000
5 4 0 0011 0011
5 0 1 00ff 00cc
5 0 0 0011 0000
5 5 0 0000 0000
6 7 0 0001 0000
6 1 1 0096 0000
6 3 0 0000 0096
6 4 0 001d 001d
6 5 0 0000 0001
6 0 1 00ff 0096
6 0 0 001d 000c
6 5 0 0000 0001
6 1 0 0000 0000
6 0 0 001d 0004
6 5 0 0000 0000
6 7 0 0000 0000

// File: verilog.f
design/uartPkg.sv
design/uartTxIf.sv
design/uartReceiver.sv
design/uartTransmitter.sv
design/uartRegisters.sv
design/uartTop.sv
tests/uartTop_checker.sv
tests/uartTb.sv

// File: Bender.yml
package:
  name: uartPeripheral

sources:
  - design/uartPkg.sv
  - design/uartTxIf.sv
  - design/uartReceiver.sv
  - design/uartTransmitter.sv
  - design/uartRegisters.sv
  - design/uartTop.sv
  - target: test
    files:
      - tests/uartTop_checker.sv
      - tests/uartTb.sv
